// File: common/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // Major opcodes kept by this cluster
    typedef enum logic [6:0]
    {
        OP_REG   = 7'b0110011,  // R-type ALU
        OP_IMM   = 7'b0010011,  // I-type ALU
        OP_LUI   = 7'b0110111,
        OP_AUIPC = 7'b0010111
    } opcode_e;

    // Exact ALU operation
    typedef enum logic [3:0]
    {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // Operand class, picks the two ALU inputs
    typedef enum logic [1:0]
    {
        SEL_RR = 2'd0,  // rs1, rs2
        SEL_RI = 2'd1,  // rs1, imm
        SEL_ZI = 2'd2,  // zero, imm (LUI)
        SEL_PI = 2'd3   // pc, imm (AUIPC)
    } opnd_sel_e;

    // Decoded control, decoder to execute
    typedef struct packed
    {
        logic        valid;
        alu_op_e     alu_op;
        opnd_sel_e   opnd_sel;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic        reg_write;  // Low for illegal words
        logic [31:0] imm;
        logic [31:0] pc;
    } ex_ctrl_t;

    // Writeback entry, execute to register file and outputs
    typedef struct packed
    {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

endpackage

`default_nettype wire

// File: verilog/rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile
    import rv_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic [4:0]  rs1_addr,
    input  wire logic [4:0]  rs2_addr,
    input  wire wb_t         wb,
    input  wire logic        wb_reg_write,
    output logic [31:0]      rs1_data,
    output logic [31:0]      rs2_data
);

    logic [31:0] regs [1:31];  // x0 has no storage

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= 32'h0;
        end
        else if (wb.valid && wb_reg_write && (wb.rd != 5'd0))
            regs[wb.rd] <= wb.data;
    end

    // Combinational read, same-edge bypass lives in execute
    assign rs1_data = (rs1_addr == 5'd0) ? 32'h0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? 32'h0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: verilog/rv_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decoder
    import rv_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0
)
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        instr_valid,
    input  wire logic [31:0] instr,
    output logic [4:0]       rs1_addr,
    output logic [4:0]       rs2_addr,
    output ex_ctrl_t         ex_ctrl,
    output logic             illegal
);

    logic [31:0] pc_q;
    logic [31:0] imm_i;   // Sign-extended I immediate
    logic [31:0] imm_u;   // Upper immediate
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic        is_reg;
    logic        fn_ok;   // funct3/funct7 combination is defined
    logic        op_ok;   // Opcode is one we execute
    logic        use_rs1;
    logic        use_rs2;
    alu_op_e     alu_op;
    opnd_sel_e   opnd_sel;
    logic [31:0] imm;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_u  = {instr[31:12], 12'b0};
    assign is_reg = (instr[6:0] == OP_REG);

    // funct3/funct7 to ALU operation, shared by R and I forms
    always_comb
    begin
        alu_op = ALU_ADD;
        fn_ok  = 1'b1;
        case (funct3)
            3'b000:
            begin
                if (is_reg)
                begin
                    alu_op = (funct7 == 7'b0100000) ? ALU_SUB : ALU_ADD;
                    fn_ok  = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end
                else
                    fn_ok = (funct7 != 7'b0100000);  // SUB-style ADDI is rejected
            end
            3'b001:
            begin
                alu_op = ALU_SLL;
                fn_ok  = (funct7 == 7'b0000000);     // SLL and SLLI alike
            end
            3'b010: alu_op = ALU_SLT;
            3'b011: alu_op = ALU_SLTU;
            3'b100: alu_op = ALU_XOR;
            3'b101:
            begin
                alu_op = (funct7 == 7'b0100000) ? ALU_SRA : ALU_SRL;  // SRA, SRAI
                fn_ok  = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
            end
            3'b110: alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
        // Logic and compare ops in R form need a zero funct7
        if (is_reg && (funct3 inside {3'b010, 3'b011, 3'b100, 3'b110, 3'b111}))
            fn_ok = (funct7 == 7'b0000000);
    end

    // Opcode class
    always_comb
    begin
        op_ok    = 1'b1;
        use_rs1  = 1'b0;
        use_rs2  = 1'b0;
        opnd_sel = SEL_RR;
        imm      = imm_i;
        case (opcode_e'(instr[6:0]))
            OP_REG:
            begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            OP_IMM:
            begin
                use_rs1  = 1'b1;
                opnd_sel = SEL_RI;
            end
            OP_LUI:
            begin
                opnd_sel = SEL_ZI;
                imm      = imm_u;
            end
            OP_AUIPC:
            begin
                opnd_sel = SEL_PI;
                imm      = imm_u;
            end
            default: op_ok = 1'b0;
        endcase
    end

    // Unused source fields read x0, so they never match a forward
    assign rs1_addr = use_rs1 ? instr[19:15] : 5'd0;
    assign rs2_addr = use_rs2 ? instr[24:20] : 5'd0;

    always_comb
    begin
        ex_ctrl.valid     = instr_valid;
        // U-type words carry no funct fields
        ex_ctrl.alu_op    = (opnd_sel inside {SEL_ZI, SEL_PI}) ? ALU_ADD : alu_op;
        ex_ctrl.opnd_sel  = opnd_sel;
        ex_ctrl.rs1       = rs1_addr;
        ex_ctrl.rs2       = rs2_addr;
        ex_ctrl.rd        = instr[11:7];
        ex_ctrl.reg_write = op_ok && (fn_ok || (opnd_sel inside {SEL_ZI, SEL_PI}));
        ex_ctrl.imm       = imm;
        ex_ctrl.pc        = pc_q;
    end

    // PC only moves on accepted words
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pc_q    <= RESET_PC;
            illegal <= 1'b0;
        end
        else
        begin
            if (instr_valid)
                pc_q <= pc_q + 32'd4;
            illegal <= instr_valid && !ex_ctrl.reg_write;  // One-cycle pulse
        end
    end

endmodule

`default_nettype wire

// File: execute/rv_alu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_alu
    import rv_pkg::*;
(
    input  wire alu_op_e     alu_op,
    input  wire logic [31:0] a,
    input  wire logic [31:0] b,
    output logic [31:0]      result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // Only low five bits shift

    always_comb
    begin
        case (alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $unsigned($signed(a) >>> shamt);  // Sign fill
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = 32'h0;
        endcase
    end

endmodule

`default_nettype wire

// File: execute/rv_execute.sv
`timescale 1ns/10ps
`default_nettype none

module rv_execute
    import rv_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire ex_ctrl_t    ex_ctrl,
    input  wire logic [31:0] rs1_data,
    input  wire logic [31:0] rs2_data,
    output wb_t              wb,
    output logic             wb_reg_write
);

    ex_ctrl_t    ex_q;          // Execute entry
    logic [31:0] rs1_q;
    logic [31:0] rs2_q;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        ex_fwd;        // Execute entry can forward
    logic        wb_fwd;        // Writeback entry can forward
    logic [31:0] rs1_sel;
    logic [31:0] rs2_sel;

    assign ex_fwd = ex_q.valid && ex_q.reg_write && (ex_q.rd != 5'd0);
    assign wb_fwd = wb.valid && wb_reg_write && (wb.rd != 5'd0);

    // Youngest producer wins
    always_comb
    begin
        if (ex_fwd && (ex_ctrl.rs1 == ex_q.rd))
            rs1_sel = alu_result;
        else if (wb_fwd && (ex_ctrl.rs1 == wb.rd))
            rs1_sel = wb.data;
        else
            rs1_sel = rs1_data;

        if (ex_fwd && (ex_ctrl.rs2 == ex_q.rd))
            rs2_sel = alu_result;
        else if (wb_fwd && (ex_ctrl.rs2 == wb.rd))
            rs2_sel = wb.data;
        else
            rs2_sel = rs2_data;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            ex_q <= '0;
        else
            ex_q <= ex_ctrl;
    end

    // Operand payload
    always_ff @(posedge clk)
    begin
        rs1_q <= rs1_sel;
        rs2_q <= rs2_sel;
    end

    // ALU inputs by operand class
    always_comb
    begin
        case (ex_q.opnd_sel)
            SEL_RR:
            begin
                alu_a = rs1_q;
                alu_b = rs2_q;
            end
            SEL_RI:
            begin
                alu_a = rs1_q;
                alu_b = ex_q.imm;
            end
            SEL_ZI:
            begin
                alu_a = 32'h0;
                alu_b = ex_q.imm;
            end
            default:
            begin
                alu_a = ex_q.pc;   // AUIPC
                alu_b = ex_q.imm;
            end
        endcase
    end

    rv_alu i_rv_alu
    (
        .alu_op (ex_q.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    // Writeback entry
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wb           <= '0;
            wb_reg_write <= 1'b0;
        end
        else
        begin
            wb.valid     <= ex_q.valid;
            wb.rd        <= ex_q.rd;
            wb.data      <= alu_result;
            wb_reg_write <= ex_q.valid && ex_q.reg_write;  // Illegal words retire dry
        end
    end

endmodule

`default_nettype wire

// File: verilog/rv_exec_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_exec_core
    import rv_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0
)
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        instr_valid,
    input  wire logic [31:0] instr,
    output logic             wb_valid,
    output logic             wb_reg_write,
    output logic [4:0]       wb_rd,
    output logic [31:0]      wb_data,
    output logic             illegal
);

    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    ex_ctrl_t    ex_ctrl;
    wb_t         wb;

    rv_decoder #(.RESET_PC(RESET_PC)) i_rv_decoder
    (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .ex_ctrl     (ex_ctrl),
        .illegal     (illegal)
    );

    rv_regfile i_rv_regfile
    (
        .clk          (clk),
        .rst          (rst),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .wb           (wb),
        .wb_reg_write (wb_reg_write),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data)
    );

    rv_execute i_rv_execute
    (
        .clk          (clk),
        .rst          (rst),
        .ex_ctrl      (ex_ctrl),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .wb           (wb),
        .wb_reg_write (wb_reg_write)
    );

    assign wb_valid = wb.valid;
    assign wb_rd    = wb.rd;
    assign wb_data  = wb.data;

endmodule

`default_nettype wire

// File: verification/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// Expected retirement of one issued word
typedef struct packed
{
    logic        write;    // Register write reported
    logic [4:0]  rd;
    logic [31:0] data;
} exp_t;

logic [31:0] shadow_regs [0:31];  // Architectural registers, x0 is never written
logic [31:0] shadow_pc;

function automatic void reset_shadow(logic [31:0] start_pc);
    for (int i = 0; i < 32; i++)
        shadow_regs[i] = 32'h0;
    shadow_pc = start_pc;
endfunction

// Legal words per the RV32I base encodings kept by the cluster
function automatic logic word_legal(logic [31:0] w);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = w[31:25];
    f3 = w[14:12];
    case (w[6:0])
        7'b0110111, 7'b0010111: return 1'b1;  // LUI, AUIPC
        7'b0110011:
            return (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'b000) || (f3 == 3'b101)));
        7'b0010011:
        begin
            if (f3 == 3'b001)
                return f7 == 7'h00;                    // SLLI
            else if (f3 == 3'b101)
                return (f7 == 7'h00) || (f7 == 7'h20);  // SRLI, SRAI
            else if (f3 == 3'b000)
                return f7 != 7'h20;                    // No SUB form of ADDI
            return 1'b1;
        end
        default: return 1'b0;
    endcase
endfunction

// Integer operation selected by funct3 and the alternate bit
function automatic logic [31:0] alu_eval(logic [2:0] f3, logic alt, logic [31:0] a,
                                         logic [31:0] b);
    case (f3)
        3'b000: return alt ? (a - b) : (a + b);
        3'b001: return a << b[4:0];
        3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011: return (a < b) ? 32'd1 : 32'd0;
        3'b100: return a ^ b;
        3'b101:
        begin
            if (alt)
                return $signed(a) >>> b[4:0];  // Sign fill
            return a >> b[4:0];
        end
        3'b110: return a | b;
        default: return a & b;
    endcase
endfunction

// Retire one word in program order and update the shadow state
function automatic exp_t step_shadow(logic [31:0] w);
    exp_t        e;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    imm_i   = {{20{w[31]}}, w[31:20]};
    imm_u   = {w[31:12], 12'h0};
    e.rd    = w[11:7];
    e.write = word_legal(w);
    e.data  = 32'h0;
    case (w[6:0])
        7'b0110011: e.data = alu_eval(w[14:12], w[30], shadow_regs[w[19:15]],
                                      shadow_regs[w[24:20]]);
        7'b0010011: e.data = alu_eval(w[14:12], w[30] && (w[14:12] == 3'b101),
                                      shadow_regs[w[19:15]], imm_i);
        7'b0110111: e.data = imm_u;
        7'b0010111: e.data = shadow_pc + imm_u;  // PC of this word
        default: e.data = 32'h0;
    endcase
    if (e.write && (e.rd != 5'd0))
        shadow_regs[e.rd] = e.data;
    shadow_pc = shadow_pc + 32'd4;  // Illegal words advance the PC as well
    return e;
endfunction

`endif

// File: verification/tb_rv_exec_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_exec_core;

    localparam logic [31:0] RESET_PC = 32'h0000_1000;
    localparam int          CLK_HALF = 20;  // 40 ns period

    logic        clk = 1'b0;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic        wb_valid;
    logic        wb_reg_write;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        illegal;

    `include "rv_ref_model.svh"

    exp_t   exp_q[$];   // Expected retirements, oldest first
    int     due_q[$];   // Edge count at which each one must show
    int     cycle = 0;  // Rising edges so far
    int     slots = 0;  // Cycles of stimulus driven
    integer seed;

    rv_exec_core #(.RESET_PC(RESET_PC)) i_rv_exec_core
    (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .wb_valid     (wb_valid),
        .wb_reg_write (wb_reg_write),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .illegal      (illegal)
    );

    always #CLK_HALF clk = ~clk;

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic report_mismatch(string msg);
        abort_run($sformatf("ERR %0t: %s", $time, msg));
    endtask

    function automatic logic [31:0] r_type_word(logic [6:0] f7, logic [4:0] rs2,
                                                logic [4:0] rs1, logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type_word(logic [11:0] imm, logic [4:0] rs1,
                                                logic [2:0] f3, logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] u_type_word(logic [6:0] opc, logic [19:0] imm,
                                                logic [4:0] rd);
        return {imm, rd, opc};
    endfunction

    // One accepted word, expectation taken at issue
    task automatic issue_word(logic [31:0] w);
        exp_t e;
        @(negedge clk);
        e           = step_shadow(w);
        instr_valid = 1'b1;
        instr       = w;
        exp_q.push_back(e);
        due_q.push_back(cycle + 2);  // Accept edge, then writeback edge
        slots = slots + 1;
    endtask

    task automatic idle_cycles(int n);
        repeat (n)
        begin
            @(negedge clk);
            instr_valid = 1'b0;
            instr       = $random(seed);  // Junk, must be ignored
            slots       = slots + 1;
        end
    endtask

    // LUI plus low part, ORI where the ADDI form would be illegal
    task automatic load_reg(logic [4:0] rd, logic [31:0] val);
        logic [31:0] hi;
        hi = val + 32'h800;  // Carry for sign-extended low part
        if (val[11:5] == 7'h20)
        begin
            issue_word(u_type_word(7'b0110111, val[31:12], rd));
            issue_word(i_type_word(val[11:0], rd, 3'b110, rd));
        end
        else
        begin
            issue_word(u_type_word(7'b0110111, hi[31:12], rd));
            issue_word(i_type_word(val[11:0], rd, 3'b000, rd));
        end
    endtask

    // Runs a quarter period after each edge, inputs and outputs are settled
    task automatic check_outputs();
        exp_t e;
        logic exp_ill;
        exp_ill = instr_valid && !word_legal(instr);  // Word accepted at this edge
        assert (illegal == exp_ill)
        else report_mismatch($sformatf("illegal is %b, expected %b", illegal, exp_ill));
        if ((due_q.size() != 0) && (due_q[0] == cycle))
        begin
            e = exp_q.pop_front();
            void'(due_q.pop_front());
            assert (wb_valid)
            else report_mismatch($sformatf("no writeback for rd x%0d", e.rd));
            assert (wb_rd == e.rd)
            else report_mismatch($sformatf("wb_rd x%0d, expected x%0d", wb_rd, e.rd));
            assert (wb_reg_write == e.write)
            else report_mismatch($sformatf("wb_reg_write %b, expected %b", wb_reg_write, e.write));
            if (e.write)
            begin
                assert (wb_data == e.data)
                else report_mismatch($sformatf("x%0d data %h, expected %h", e.rd, wb_data, e.data));
            end
        end
        else
        begin
            assert (!wb_valid)
            else report_mismatch("writeback with nothing pending");
        end
    endtask

    always @(posedge clk)
    begin
        cycle = cycle + 1;
        #(CLK_HALF / 2);
        if (!rst)
            check_outputs();
    end

    // Watchdog, the stimulus length plus 20 cycles of slack
    always @(posedge clk)
    begin
        #1;
        if (cycle > slots + 20)
            abort_run($sformatf("Timeout: the run went %0d cycles for %0d cycles of stimulus",
                                cycle, slots));
    end

    // Outputs quiet while idle, then exact two-edge latency
    task automatic after_reset_check();
        idle_cycles(4);
        issue_word(i_type_word(12'h05a, 5'd0, 3'b000, 5'd1));
        idle_cycles(3);
    endtask

    task automatic alu_sweep();
        int          round;
        int          f;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        for (round = 0; round < 4; round++)
        begin
            a = $random(seed);
            b = (round == 1) ? a : $random(seed);  // Equal operands once
            load_reg(5'd1, a);
            load_reg(5'd2, b);
            for (f = 0; f < 8; f++)
                issue_word(r_type_word(7'h00, 5'd2, 5'd1, 3'(f), 5'(3 + f)));
            issue_word(r_type_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd11));  // SUB
            issue_word(r_type_word(7'h20, 5'd2, 5'd1, 3'b101, 5'd12));  // SRA
            for (f = 0; f < 8; f++)
            begin
                r = $random(seed);
                if ((f == 1) || (f == 5))
                    r[11:5] = 7'h00;          // Shift amount only
                if ((f == 0) && (r[11:5] == 7'h20))
                    r[11] = 1'b1;             // Keep ADDI legal
                issue_word(i_type_word(r[11:0], 5'd1, 3'(f), 5'(13 + f)));
            end
            r = $random(seed);
            issue_word(i_type_word({7'h20, r[4:0]}, 5'd1, 3'b101, 5'd21));  // SRAI
        end
    endtask

    task automatic forwarding_chains();
        int          d;
        int          k;
        logic [31:0] r;
        load_reg(5'd7, $random(seed));
        for (d = 1; d <= 3; d++)
        begin
            r = $random(seed);
            issue_word(i_type_word({1'b1, r[10:0]}, 5'd0, 3'b000, 5'd5));
            for (k = 1; k < d; k++)
                issue_word(i_type_word(12'h055, 5'd9, 3'b100, 5'd9));  // Unrelated filler
            issue_word(r_type_word(7'h00, 5'd7, 5'd5, 3'b000, 5'd6));  // x5 on rs1
            r = $random(seed);
            issue_word(i_type_word({1'b0, r[10:0]}, 5'd0, 3'b110, 5'd5));
            for (k = 1; k < d; k++)
                issue_word(i_type_word(12'h0aa, 5'd9, 3'b100, 5'd9));
            issue_word(r_type_word(7'h20, 5'd5, 5'd7, 3'b000, 5'd6));  // x5 on rs2
        end
        // Two producers in flight, the younger one wins
        issue_word(i_type_word(12'h123, 5'd0, 3'b000, 5'd5));
        issue_word(i_type_word(12'hffd, 5'd0, 3'b000, 5'd5));
        issue_word(r_type_word(7'h00, 5'd5, 5'd5, 3'b000, 5'd6));
        // Chain through one register
        repeat (3)
            issue_word(i_type_word(12'h011, 5'd5, 3'b000, 5'd5));
        issue_word(r_type_word(7'h00, 5'd5, 5'd5, 3'b001, 5'd6));
        // Gap turns distance one into the writeback path
        issue_word(i_type_word(12'h3c3, 5'd0, 3'b000, 5'd5));
        idle_cycles(1);
        issue_word(r_type_word(7'h00, 5'd5, 5'd7, 3'b111, 5'd6));
    endtask

    task automatic x0_writes();
        load_reg(5'd1, $random(seed));
        issue_word(i_type_word(12'h123, 5'd0, 3'b000, 5'd0));   // Reports write to x0
        issue_word(r_type_word(7'h00, 5'd1, 5'd0, 3'b000, 5'd8));
        issue_word(i_type_word(12'h005, 5'd1, 3'b000, 5'd0));
        issue_word(i_type_word(12'h001, 5'd9, 3'b100, 5'd9));
        issue_word(r_type_word(7'h00, 5'd0, 5'd0, 3'b000, 5'd8));  // Distance two
        issue_word(u_type_word(7'b0110111, 20'hfffff, 5'd0));
        issue_word(r_type_word(7'h00, 5'd0, 5'd1, 3'b110, 5'd8));  // x0 on rs2
    endtask

    // AUIPC tracks accepted words only
    task automatic upper_immediates();
        issue_word(u_type_word(7'b0110111, 20'($random(seed)), 5'd14));
        issue_word(u_type_word(7'b0010111, 20'($random(seed)), 5'd15));
        idle_cycles(2);
        issue_word(u_type_word(7'b0010111, 20'($random(seed)), 5'd16));
        idle_cycles(1);
        issue_word(u_type_word(7'b0010111, 20'h00000, 5'd17));
        issue_word(r_type_word(7'h00, 5'd17, 5'd16, 3'b000, 5'd18));
    endtask

    task automatic illegal_words();
        issue_word(i_type_word(12'h007, 5'd0, 3'b000, 5'd11));
        issue_word({12'h000, 5'd0, 3'b010, 5'd11, 7'b0000011});     // Load
        issue_word(r_type_word(7'h00, 5'd0, 5'd11, 3'b000, 5'd12));  // Still 7
        issue_word(i_type_word(12'h403, 5'd0, 3'b000, 5'd11));       // SUB-style ADDI
        issue_word(r_type_word(7'h01, 5'd2, 5'd1, 3'b000, 5'd11));   // MUL space
        issue_word(i_type_word({7'h20, 5'd4}, 5'd1, 3'b001, 5'd11));
        issue_word(r_type_word(7'h20, 5'd2, 5'd1, 3'b100, 5'd11));
        issue_word(32'h00b58463);                                    // Branch
        issue_word(32'h00000000);
        issue_word(r_type_word(7'h00, 5'd11, 5'd11, 3'b000, 5'd12));
        issue_word(u_type_word(7'b0010111, 20'h00001, 5'd13));
    endtask

    initial
    begin
        seed        = 83999;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = 32'h0;
        reset_shadow(RESET_PC);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        after_reset_check();
        alu_sweep();
        forwarding_chains();
        x0_writes();
        upper_immediates();
        illegal_words();
        idle_cycles(1);
        while (exp_q.size() != 0)
            @(negedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+verification
common/rv_pkg.sv
verilog/rv_regfile.sv
verilog/rv_decoder.sv
execute/rv_alu.sv
execute/rv_execute.sv
verilog/rv_exec_core.sv
verification/tb_rv_exec_core.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rv_exec_core \
    -f all.f --Mdir obj_dir -o tb_rv_exec_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_rv_exec_core 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
